//--- source/ldpc_check_cfg.svh
`ifndef LDPC_CHECK_CFG_SVH
`define LDPC_CHECK_CFG_SVH

// lifting factor, bits per block column
`define LDPC_LIFT 16

// base matrix shape
`define LDPC_ROW_BLOCKS 4
`define LDPC_COL_BLOCKS 8

// lifting index and cyclic shift width
`define LDPC_IDX_W 4

// enough for every check in the code (4 x 16 = 64)
`define LDPC_WEIGHT_W 7

`endif

//--- source/ldpc_check_pkg.sv
`include "ldpc_check_cfg.svh"

package ldpc_check_pkg;

    // block column c sits at bits c*LIFT +: LIFT
    typedef logic [`LDPC_COL_BLOCKS*`LDPC_LIFT-1:0] codeword_t;
    typedef logic [`LDPC_IDX_W-1:0]                 lift_idx_t;
    typedef logic [`LDPC_ROW_BLOCKS-1:0]            check_vec_t;
    typedef logic [`LDPC_WEIGHT_W-1:0]              weight_t;

    // decode to execute
    typedef struct packed {
        logic      valid;
        lift_idx_t idx;
        logic      last;
    } row_step_t;

    // execute to result
    typedef struct packed {
        logic       valid;
        check_vec_t bits;
        logic       last;
    } check_res_t;

    typedef enum logic {
        seq_idle,
        seq_run
    } seq_state_t;

    // cyclic shift per base matrix entry, row r then column c
    localparam lift_idx_t base_shift [`LDPC_ROW_BLOCKS][`LDPC_COL_BLOCKS] = '{
        '{4'd3,  4'd11, 4'd0,  4'd7,  4'd14, 4'd0,  4'd0,  4'd0},
        '{4'd0,  4'd5,  4'd9,  4'd0,  4'd2,  4'd12, 4'd0,  4'd0},
        '{4'd13, 4'd0,  4'd6,  4'd1,  4'd0,  4'd8,  4'd15, 4'd0},
        '{4'd10, 4'd0,  4'd4,  4'd0,  4'd9,  4'd0,  4'd7,  4'd1}
    };

    // block present, bit c is column c
    localparam logic [`LDPC_COL_BLOCKS-1:0] base_mask [`LDPC_ROW_BLOCKS] = '{
        8'b0001_1011,
        8'b0011_0110,
        8'b0110_1101,
        8'b1101_0101
    };

endpackage

//--- source/ldpc_row_sequencer.sv
`timescale 1ns/10ps
`include "ldpc_check_cfg.svh"

module ldpc_row_sequencer (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       check_start,
    output ldpc_check_pkg::row_step_t  step
);

    ldpc_check_pkg::seq_state_t state;
    ldpc_check_pkg::seq_state_t state_next;
    ldpc_check_pkg::lift_idx_t  idx_cnt;
    logic                       idx_last;

    assign idx_last = (idx_cnt == ldpc_check_pkg::lift_idx_t'(`LDPC_LIFT - 1));

    // start is only honoured when idle
    always_comb begin
        state_next = state;
        case (state)
            ldpc_check_pkg::seq_idle: begin
                if (check_start) begin
                    state_next = ldpc_check_pkg::seq_run;
                end
            end
            ldpc_check_pkg::seq_run: begin
                if (idx_last) begin
                    state_next = ldpc_check_pkg::seq_idle;
                end
            end
            default: state_next = ldpc_check_pkg::seq_idle;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= ldpc_check_pkg::seq_idle;
        end else begin
            state <= state_next;
        end
    end

    // one lifting index per cycle, wraps back to 0 after the last
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            idx_cnt <= '0;
        end else if (state == ldpc_check_pkg::seq_run) begin
            idx_cnt <= idx_cnt + 1'b1;
        end else begin
            idx_cnt <= '0;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step <= '0;
        end else begin
            step.valid <= (state == ldpc_check_pkg::seq_run);
            step.idx   <= idx_cnt;
            step.last  <= (state == ldpc_check_pkg::seq_run) && idx_last;
        end
    end

endmodule

//--- source/ldpc_check_eval.sv
`timescale 1ns/10ps
`include "ldpc_check_cfg.svh"

module ldpc_check_eval (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  ldpc_check_pkg::row_step_t   step,
    input  ldpc_check_pkg::codeword_t   codeword,
    output ldpc_check_pkg::check_res_t  check
);

    // in-block address of each edge
    ldpc_check_pkg::lift_idx_t  edge_addr [`LDPC_ROW_BLOCKS][`LDPC_COL_BLOCKS];
    ldpc_check_pkg::check_vec_t parity;

    logic                       chk_valid;
    logic                       chk_last;
    ldpc_check_pkg::check_vec_t chk_bits;

    // the add wraps at 4 bits, which is mod LIFT
    always_comb begin
        for (int r = 0; r < `LDPC_ROW_BLOCKS; r++) begin
            for (int c = 0; c < `LDPC_COL_BLOCKS; c++) begin
                edge_addr[r][c] = step.idx + ldpc_check_pkg::base_shift[r][c];
            end
        end
    end

    // xor of the selected bits in each block row
    always_comb begin
        for (int r = 0; r < `LDPC_ROW_BLOCKS; r++) begin
            parity[r] = 1'b0;
            for (int c = 0; c < `LDPC_COL_BLOCKS; c++) begin
                if (ldpc_check_pkg::base_mask[r][c]) begin
                    parity[r] = parity[r] ^ codeword[c*`LDPC_LIFT + edge_addr[r][c]];
                end
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            chk_valid <= 1'b0;
            chk_last  <= 1'b0;
        end else begin
            chk_valid <= step.valid;
            chk_last  <= step.valid && step.last;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (step.valid) begin
            chk_bits <= parity;
        end
    end

    assign check = '{valid: chk_valid, bits: chk_bits, last: chk_last};

endmodule

//--- source/ldpc_syndrome_accum.sv
`timescale 1ns/10ps
`include "ldpc_check_cfg.svh"

module ldpc_syndrome_accum (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  ldpc_check_pkg::check_res_t  check,
    output logic                        check_done,
    output ldpc_check_pkg::weight_t     syndrome_weight
);

    ldpc_check_pkg::weight_t chk_ones;
    ldpc_check_pkg::weight_t sum_acc;
    ldpc_check_pkg::weight_t sum_next;

    // unsatisfied checks in this item
    always_comb begin
        chk_ones = '0;
        for (int r = 0; r < `LDPC_ROW_BLOCKS; r++) begin
            chk_ones = chk_ones + ldpc_check_pkg::weight_t'(check.bits[r]);
        end
    end

    assign sum_next = sum_acc + chk_ones;

    // running sum, emptied on the last item so the next run starts at zero
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sum_acc <= '0;
        end else if (check.valid) begin
            if (check.last) begin
                sum_acc <= '0;
            end else begin
                sum_acc <= sum_next;
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            check_done <= 1'b0;
        end else begin
            check_done <= check.valid && check.last;
        end
    end

    // held until the next run finishes
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            syndrome_weight <= '0;
        end else if (check.valid && check.last) begin
            syndrome_weight <= sum_next;
        end
    end

endmodule

//--- source/ldpc_syndrome_check.sv
`timescale 1ns/10ps

module ldpc_syndrome_check (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       check_start,
    input  ldpc_check_pkg::codeword_t  codeword,
    output logic                       check_done,
    output ldpc_check_pkg::weight_t    syndrome_weight
);

    ldpc_check_pkg::row_step_t  step;
    ldpc_check_pkg::check_res_t check;

    // index walk
    ldpc_row_sequencer ldpc_row_sequencer_inst (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .check_start (check_start),
        .step        (step)
    );

    // shifted reads and row parity
    ldpc_check_eval ldpc_check_eval_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step      (step),
        .codeword  (codeword),
        .check     (check)
    );

    // count and report
    ldpc_syndrome_accum ldpc_syndrome_accum_inst (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .check           (check),
        .check_done      (check_done),
        .syndrome_weight (syndrome_weight)
    );

endmodule

//--- verif/ldpc_syndrome_check_tb.sv
`timescale 1ns/10ps
`include "ldpc_check_cfg.svh"

module ldpc_syndrome_check_tb;

    localparam int DONE_LATENCY = 18;
    localparam int WAIT_LIMIT   = 100;
    localparam int NUM_RANDOM   = 6;

    typedef struct packed {
        ldpc_check_pkg::codeword_t codeword;
        ldpc_check_pkg::weight_t   weight;
        logic [4:0]                restart_at;
    } vector_t;

    logic                      sys_clk;
    logic                      sys_rst_n;
    logic                      check_start;
    ldpc_check_pkg::codeword_t codeword;
    logic                      check_done;
    ldpc_check_pkg::weight_t   syndrome_weight;

    vector_t                   vectors [$];
    logic [31:0]               rng_state;
    ldpc_check_pkg::weight_t   held_weight;

    ldpc_syndrome_check ldpc_syndrome_check_inst (
        .sys_clk         (sys_clk),
        .sys_rst_n       (sys_rst_n),
        .check_start     (check_start),
        .codeword        (codeword),
        .check_done      (check_done),
        .syndrome_weight (syndrome_weight)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #2 sys_clk = ~sys_clk;
        end
    end

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_weight(string name, ldpc_check_pkg::weight_t expected,
                                ldpc_check_pkg::weight_t actual);
        if (actual !== expected) begin
            report_error($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            report_error($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic ldpc_check_pkg::codeword_t random_codeword();
        ldpc_check_pkg::codeword_t cw;
        for (int w = 0; w < 4; w++) begin
            rng_state = xorshift32(rng_state);
            cw[w*32 +: 32] = rng_state;
        end
        return cw;
    endfunction

    function automatic ldpc_check_pkg::codeword_t single_bit(int pos);
        ldpc_check_pkg::codeword_t cw;
        cw      = '0;
        cw[pos] = 1'b1;
        return cw;
    endfunction

    // check r*LIFT + i reads bit (i + shift) mod LIFT of every present block in row r
    function automatic ldpc_check_pkg::weight_t reference_weight(
        ldpc_check_pkg::codeword_t cw
    );
        int   count;
        int   pos;
        logic parity;
        count = 0;
        for (int r = 0; r < `LDPC_ROW_BLOCKS; r++) begin
            for (int i = 0; i < `LDPC_LIFT; i++) begin
                parity = 1'b0;
                for (int c = 0; c < `LDPC_COL_BLOCKS; c++) begin
                    if (ldpc_check_pkg::base_mask[r][c]) begin
                        pos    = c * `LDPC_LIFT
                               + ((i + int'(ldpc_check_pkg::base_shift[r][c])) % `LDPC_LIFT);
                        parity = parity ^ cw[pos];
                    end
                end
                count = count + int'(parity);
            end
        end
        return ldpc_check_pkg::weight_t'(count);
    endfunction

    function automatic vector_t make_vector(ldpc_check_pkg::codeword_t cw, int weight,
                                            int restart_at);
        vector_t vec;
        vec.codeword   = cw;
        vec.weight     = ldpc_check_pkg::weight_t'(weight);
        vec.restart_at = 5'(restart_at);
        return vec;
    endfunction

    task automatic build_vectors();
        ldpc_check_pkg::codeword_t cw;
        vectors.push_back(make_vector('0, 0, 0));
        // rows 2 and 3 have odd degree
        vectors.push_back(make_vector('1, 32, 7));
        // single bit, weight is the column degree
        vectors.push_back(make_vector(single_bit(0*16 + 5), 3, 0));
        vectors.push_back(make_vector(single_bit(1*16 + 0), 2, 4));
        vectors.push_back(make_vector(single_bit(2*16 + 15), 3, 0));
        vectors.push_back(make_vector(single_bit(3*16 + 8), 2, 12));
        vectors.push_back(make_vector(single_bit(4*16 + 3), 3, 0));
        vectors.push_back(make_vector(single_bit(5*16 + 11), 2, 0));
        vectors.push_back(make_vector(single_bit(6*16 + 6), 2, 15));
        vectors.push_back(make_vector(single_bit(7*16 + 14), 1, 0));
        // both bits land in check 48 and cancel there
        vectors.push_back(make_vector(single_bit(10) | single_bit(7*16 + 1), 2, 0));
        for (int k = 0; k < NUM_RANDOM; k++) begin
            cw = random_codeword();
            vectors.push_back(make_vector(cw, int'(reference_weight(cw)), (k % 2) * 9));
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic apply_vector(vector_t vec);
        int cycles;
        cycles      = 0;
        codeword    = vec.codeword;
        check_start = 1'b1;
        @(posedge sys_clk);
        #1;
        check_start = 1'b0;
        while (!check_done && cycles < WAIT_LIMIT) begin
            check_weight("syndrome_weight", held_weight, syndrome_weight);
            // extra start mid-run, should be ignored
            check_start = (vec.restart_at != 0) && (cycles == int'(vec.restart_at));
            @(posedge sys_clk);
            #1;
            cycles++;
        end
        check_start = 1'b0;
        if (!check_done) begin
            report_error("check_done never arrived within the timeout");
        end
        if (cycles != DONE_LATENCY) begin
            report_error($sformatf("check_done arrived %0d cycles after start instead of %0d",
                                   cycles, DONE_LATENCY));
        end
        check_weight("syndrome_weight", vec.weight, syndrome_weight);
        held_weight = vec.weight;
        @(posedge sys_clk);
        #1;
        check_flag("check_done", 1'b0, check_done);
        check_weight("syndrome_weight", held_weight, syndrome_weight);
    endtask

    initial begin
        sys_rst_n   = 1'b0;
        check_start = 1'b0;
        codeword    = '0;
        held_weight = '0;
        rng_state   = 32'd3418;
        build_vectors();
        repeat (10) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;
        // idle, nothing started yet
        for (int n = 0; n < 5; n++) begin
            check_flag("check_done", 1'b0, check_done);
            check_weight("syndrome_weight", '0, syndrome_weight);
            @(posedge sys_clk);
            #1;
        end
        foreach (vectors[k]) begin
            apply_vector(vectors[k]);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/ldpc_check_pkg.sv
source/ldpc_row_sequencer.sv
source/ldpc_check_eval.sv
source/ldpc_syndrome_accum.sv
source/ldpc_syndrome_check.sv
verif/ldpc_syndrome_check_tb.sv

//--- Bender.yml
package:
  name: ldpc_syndrome_check

sources:
  - include_dirs:
      - source
    files:
      - source/ldpc_check_pkg.sv
      - source/ldpc_row_sequencer.sv
      - source/ldpc_check_eval.sv
      - source/ldpc_syndrome_accum.sv
      - source/ldpc_syndrome_check.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/ldpc_syndrome_check_tb.sv
